// File: design/umtrx_ctrl_pkg.sv
// Control-plane definitions for the radio core
// Bus widths, Wishbone window decode, settings address map,
// readback word indexes, reset values and state encodings

package umtrx_ctrl_pkg;

   // Wishbone geometry, byte addressed
   localparam int WB_DW    = 32;
   localparam int WB_AW    = 16;
   localparam int SET_AW   = 8;
   localparam int DECODE_W = 8;

   // Window decode on the top address byte
   localparam logic [DECODE_W-1:0] SETTINGS_WIN  = 8'h70;
   localparam logic [DECODE_W-1:0] SETTINGS_MASK = 8'hF0;
   localparam logic [DECODE_W-1:0] READBACK_WIN  = 8'h5C;
   localparam logic [DECODE_W-1:0] READBACK_MASK = 8'hFC;

   // Settings bus bases
   localparam int SR_MISC  = 0;
   localparam int SR_DIVSW = 180;

   // Offsets from SR_MISC, 1 and 2 are reserved
   typedef enum logic [SET_AW-1:0] {
      MISC_LMS_RES = 8'd0,
      MISC_LED_SW  = 8'd3,
      MISC_PHY     = 8'd4,
      MISC_BLDR    = 8'd5,
      MISC_LED_SRC = 8'd6
   } misc_reg_e;

   // Readback word indexes
   typedef enum logic [SET_AW-1:0] {
      RB_COMPAT = 8'd12,
      RB_STATUS = 8'd13
   } rb_word_e;

   // Major number high, minor number low
   localparam logic [WB_DW-1:0] COMPAT_NUM = {16'd9, 16'd0};

   localparam int LED_W = 8;
   localparam int RUN_W = 4;
   localparam logic [LED_W-1:0] LED_SRC_RESET = 8'h1E;
   localparam logic             DIVSW_RESET   = 1'b1;

   typedef enum logic {
      BOOT_WAIT = 1'b0,
      BOOT_DONE = 1'b1
   } boot_state_e;

endpackage

// File: design/settings_wb_slave.sv
// Wishbone slave for the control plane
// Writes in the settings window become one-cycle settings-bus strobes,
// reads in the readback window return the compatibility and status words.
// Every access is acknowledged for one cycle, one edge after the request.

module settings_wb_slave #(
   parameter logic [umtrx_ctrl_pkg::WB_DW-1:0]    COMPAT   = umtrx_ctrl_pkg::COMPAT_NUM,
   parameter logic [umtrx_ctrl_pkg::DECODE_W-1:0] READ_WIN = umtrx_ctrl_pkg::READBACK_WIN,
   parameter logic [umtrx_ctrl_pkg::DECODE_W-1:0] SET_WIN  = umtrx_ctrl_pkg::SETTINGS_WIN
) (
   input  logic                                wb_clk,
   input  logic                                wb_rst_i,
   input  logic [umtrx_ctrl_pkg::WB_AW-1:0]    wb_adr_i,
   input  logic [umtrx_ctrl_pkg::WB_DW-1:0]    wb_dat_i,
   input  logic                                wb_we_i,
   input  logic                                wb_stb_i,
   input  logic                                wb_cyc_i,
   input  logic                                aux_ld1_i,
   input  logic                                aux_ld2_i,
   input  logic                                button_i,
   output logic [umtrx_ctrl_pkg::WB_DW-1:0]    wb_dat_o,
   output logic                                wb_ack_o,
   output logic                                set_stb_o,
   output logic [umtrx_ctrl_pkg::SET_AW-1:0]   set_addr_o,
   output logic [umtrx_ctrl_pkg::WB_DW-1:0]    set_data_o
);
   import umtrx_ctrl_pkg::*;

   logic [DECODE_W-1:0] win;
   logic [SET_AW-1:0]   word_idx;
   logic                set_hit;
   logic                rb_hit;
   logic                req;
   logic                set_wr;
   logic [WB_DW-1:0]    status_word;
   logic [WB_DW-1:0]    rd_word;

   assign win      = wb_adr_i[WB_AW-1 -: DECODE_W];
   assign word_idx = wb_adr_i[SET_AW+1:2];
   assign set_hit  = (win & SETTINGS_MASK) == (SET_WIN & SETTINGS_MASK);
   assign rb_hit   = (win & READBACK_MASK) == (READ_WIN & READBACK_MASK);

   // New request only while ack is low, so ack never stretches
   assign req    = wb_stb_i & wb_cyc_i & ~wb_ack_o;
   assign set_wr = req & wb_we_i & set_hit;

   // Bit 12 was the SPI ready flag, no SPI core here
   assign status_word = {16'b0, aux_ld2_i, aux_ld1_i, button_i, 1'b0, 12'b0};

   always_comb begin
      case (word_idx)
         RB_COMPAT: rd_word = COMPAT;
         RB_STATUS: rd_word = status_word;
         default:   rd_word = '0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Handshake and strobe

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         wb_ack_o  <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         wb_ack_o  <= req;
         set_stb_o <= set_wr;
      end
   end

   // Settings payload, only meaningful with set_stb_o
   always_ff @(posedge wb_clk) begin
      if (set_wr) begin
         set_addr_o <= word_idx;
         set_data_o <= wb_dat_i;
      end
   end

   // Read data, zero outside the readback window and on writes
   always_ff @(posedge wb_clk) begin
      wb_dat_o <= (req && !wb_we_i && rb_hit) ? rd_word : '0;
   end

endmodule

// File: design/misc_settings_regs.sv
// Miscellaneous settings registers
// Decodes settings-bus writes into the LMS reset, PHY reset,
// bootloader-done, LED and diversity switch registers.
// LED pins mix hardware run flags and software bits under a source mask.

module misc_settings_regs #(
   parameter int MISC_BASE  = umtrx_ctrl_pkg::SR_MISC,
   parameter int DIVSW_BASE = umtrx_ctrl_pkg::SR_DIVSW
) (
   input  logic                               wb_clk,
   input  logic                               wb_rst_i,
   input  logic                               set_stb_i,
   input  logic [umtrx_ctrl_pkg::SET_AW-1:0]  set_addr_i,
   input  logic [umtrx_ctrl_pkg::WB_DW-1:0]   set_data_i,
   input  logic [umtrx_ctrl_pkg::RUN_W-1:0]   run_flags_i,
   output logic [1:0]                         lms_res_o,
   output logic                               phy_resetn_o,
   output logic                               bldr_done_o,
   output logic                               div_sw1_o,
   output logic                               div_sw2_o,
   output logic [umtrx_ctrl_pkg::LED_W-1:0]   leds_o
);
   import umtrx_ctrl_pkg::*;

   // Absolute settings addresses
   localparam logic [SET_AW-1:0] A_LMS_RES = SET_AW'(MISC_BASE + int'(MISC_LMS_RES));
   localparam logic [SET_AW-1:0] A_LED_SW  = SET_AW'(MISC_BASE + int'(MISC_LED_SW));
   localparam logic [SET_AW-1:0] A_PHY     = SET_AW'(MISC_BASE + int'(MISC_PHY));
   localparam logic [SET_AW-1:0] A_BLDR    = SET_AW'(MISC_BASE + int'(MISC_BLDR));
   localparam logic [SET_AW-1:0] A_LED_SRC = SET_AW'(MISC_BASE + int'(MISC_LED_SRC));
   localparam logic [SET_AW-1:0] A_DIVSW1  = SET_AW'(DIVSW_BASE);
   localparam logic [SET_AW-1:0] A_DIVSW2  = SET_AW'(DIVSW_BASE + 1);

   logic             phy_rst_q;
   logic [LED_W-1:0] led_sw_q;
   logic [LED_W-1:0] led_src_q;
   logic [LED_W-1:0] led_hw;

   //////////////////////////////////////////////////////////////////////
   // Register writes, each keeps the low bits at its width

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         lms_res_o   <= 2'b00;
         phy_rst_q   <= 1'b0;
         bldr_done_o <= 1'b0;
         led_sw_q    <= '0;
         led_src_q   <= LED_SRC_RESET;
         div_sw1_o   <= DIVSW_RESET;
         div_sw2_o   <= DIVSW_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            A_LMS_RES: lms_res_o   <= set_data_i[1:0];
            A_LED_SW:  led_sw_q    <= set_data_i[LED_W-1:0];
            A_PHY:     phy_rst_q   <= set_data_i[0];
            A_BLDR:    bldr_done_o <= set_data_i[0];
            A_LED_SRC: led_src_q   <= set_data_i[LED_W-1:0];
            A_DIVSW1:  div_sw1_o   <= set_data_i[0];
            A_DIVSW2:  div_sw2_o   <= set_data_i[0];
            default:   ;
         endcase
      end
   end

   assign phy_resetn_o = ~phy_rst_q;

   //////////////////////////////////////////////////////////////////////
   // LED mix

   // Run flags in bits 4..1, first flag (MSB of run_flags_i) at bit 4
   assign led_hw = {{(LED_W-RUN_W-1){1'b0}}, run_flags_i, 1'b0};

   // Mask bit 1 takes hardware, 0 takes software
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

// File: design/boot_reset_ctrl.sv
// Bootloader handover reset
// Holds the internal reset during power-on reset, then gives one
// extra reset pulse on the first bootloader-done after power-on.
// Later bootloader-done writes are ignored.

module boot_reset_ctrl (
   input  logic wb_clk,
   input  logic por_rst,
   input  logic bldr_done_i,
   output logic wb_rst_o
);
   import umtrx_ctrl_pkg::*;

   boot_state_e state;
   logic        rst_pulse;

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         state     <= BOOT_WAIT;
         rst_pulse <= 1'b0;
      end else begin
         rst_pulse <= 1'b0;
         case (state)
            BOOT_WAIT: begin
               if (bldr_done_i) begin
                  state     <= BOOT_DONE;
                  rst_pulse <= 1'b1;
               end
            end
            // Stays here until the next power-on reset
            BOOT_DONE: state <= BOOT_DONE;
            default:   state <= BOOT_WAIT;
         endcase
      end
   end

   assign wb_rst_o = por_rst | rst_pulse;

endmodule

// File: design/umtrx_ctrl_top.sv
// Control-plane top level
// Wishbone slave feeding the settings registers over the settings bus,
// with the bootloader handover controller forming the internal reset

module umtrx_ctrl_top (
   input  logic                               wb_clk,
   input  logic                               por_rst,
   // Wishbone slave
   input  logic [umtrx_ctrl_pkg::WB_AW-1:0]   wb_adr_i,
   input  logic [umtrx_ctrl_pkg::WB_DW-1:0]   wb_dat_i,
   output logic [umtrx_ctrl_pkg::WB_DW-1:0]   wb_dat_o,
   input  logic                               wb_we_i,
   input  logic                               wb_stb_i,
   input  logic                               wb_cyc_i,
   output logic                               wb_ack_o,
   // Status and run inputs
   input  logic                               aux_ld1_i,
   input  logic                               aux_ld2_i,
   input  logic                               button_i,
   input  logic [umtrx_ctrl_pkg::RUN_W-1:0]   run_flags_i,
   // Control outputs
   output logic [1:0]                         lms_res_o,
   output logic                               phy_resetn_o,
   output logic                               div_sw1_o,
   output logic                               div_sw2_o,
   output logic [umtrx_ctrl_pkg::LED_W-1:0]   leds_o
);
   import umtrx_ctrl_pkg::*;

   logic              wb_rst;
   logic              bldr_done;
   logic              set_stb;
   logic [SET_AW-1:0] set_addr;
   logic [WB_DW-1:0]  set_data;

   //////////////////////////////////////////////////////////////////////
   // Bus side

   settings_wb_slave #(
      .COMPAT   (COMPAT_NUM),
      .READ_WIN (READBACK_WIN),
      .SET_WIN  (SETTINGS_WIN)
   ) i_settings_wb_slave (
      .wb_clk     (wb_clk),
      .wb_rst_i   (wb_rst),
      .wb_adr_i   (wb_adr_i),
      .wb_dat_i   (wb_dat_i),
      .wb_we_i    (wb_we_i),
      .wb_stb_i   (wb_stb_i),
      .wb_cyc_i   (wb_cyc_i),
      .aux_ld1_i  (aux_ld1_i),
      .aux_ld2_i  (aux_ld2_i),
      .button_i   (button_i),
      .wb_dat_o   (wb_dat_o),
      .wb_ack_o   (wb_ack_o),
      .set_stb_o  (set_stb),
      .set_addr_o (set_addr),
      .set_data_o (set_data)
   );

   //////////////////////////////////////////////////////////////////////
   // Register side

   misc_settings_regs #(
      .MISC_BASE  (SR_MISC),
      .DIVSW_BASE (SR_DIVSW)
   ) i_misc_settings_regs (
      .wb_clk       (wb_clk),
      .wb_rst_i     (wb_rst),
      .set_stb_i    (set_stb),
      .set_addr_i   (set_addr),
      .set_data_i   (set_data),
      .run_flags_i  (run_flags_i),
      .lms_res_o    (lms_res_o),
      .phy_resetn_o (phy_resetn_o),
      .bldr_done_o  (bldr_done),
      .div_sw1_o    (div_sw1_o),
      .div_sw2_o    (div_sw2_o),
      .leds_o       (leds_o)
   );

   // Internal reset for both blocks above
   boot_reset_ctrl i_boot_reset_ctrl (
      .wb_clk      (wb_clk),
      .por_rst     (por_rst),
      .bldr_done_i (bldr_done),
      .wb_rst_o    (wb_rst)
   );

endmodule

// File: tests/umtrx_ctrl_checker.sv
// Result checker for the control-plane testbench
// Compares read data on ack and the packed pin word on a pin check
// against the expected value, reports each test and the totals

module umtrx_ctrl_checker (
   input  logic        wb_clk,
   input  logic        wb_ack_i,
   input  logic [31:0] wb_dat_i,
   input  logic [31:0] pins_i,
   input  logic        rd_chk_i,
   input  logic        pin_chk_i,
   input  logic [31:0] exp_i,
   input  logic [7:0]  test_i,
   input  logic        test_end_i,
   input  logic        done_i,
   output int          err_cnt_o,
   output int          chk_cnt_o
);

   int err_cnt  = 0;
   int chk_cnt  = 0;
   int test_err = 0;
   int test_cnt = 0;

   assign err_cnt_o = err_cnt;
   assign chk_cnt_o = chk_cnt;

   always @(posedge wb_clk) begin
      // Read data is valid while ack is high
      if (rd_chk_i && wb_ack_i) begin
         chk_cnt++;
         if (wb_dat_i !== exp_i) begin
            $display("mismatch at %0t: test %0d read data %h, expected %h",
                     $time, test_i, wb_dat_i, exp_i);
            err_cnt++;
            test_err++;
         end
      end
      if (pin_chk_i) begin
         chk_cnt++;
         if (pins_i !== exp_i) begin
            $display("mismatch at %0t: test %0d pins %h, expected %h",
                     $time, test_i, pins_i, exp_i);
            err_cnt++;
            test_err++;
         end
      end
      if (test_end_i) begin
         test_cnt++;
         if (test_err == 0)
            $display("test %0d: ok", test_i);
         else
            $display("test %0d: %0d errors", test_i, test_err);
         test_err = 0;
      end
      if (done_i)
         $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
   end

endmodule

// File: tests/umtrx_ctrl_assert.sv
// Bound assertions for the control-plane top level
// Wishbone handshake shape, settings strobe timing and reset values

module umtrx_ctrl_assert (
   input logic                             wb_clk,
   input logic                             por_rst,
   input logic                             wb_stb_i,
   input logic                             wb_cyc_i,
   input logic                             wb_ack_o,
   input logic                             set_stb_i,
   input logic [1:0]                       lms_res_o,
   input logic                             phy_resetn_o,
   input logic                             div_sw1_o,
   input logic                             div_sw2_o,
   input logic [umtrx_ctrl_pkg::LED_W-1:0] leds_o,
   input logic [umtrx_ctrl_pkg::RUN_W-1:0] run_flags_i
);
   import umtrx_ctrl_pkg::*;

   ack_one_cycle: assert property (@(posedge wb_clk) disable iff (por_rst)
      wb_ack_o |=> !wb_ack_o)
      else $error("ack stayed high for more than one cycle");

   ack_needs_req: assert property (@(posedge wb_clk) disable iff (por_rst)
      wb_ack_o |-> $past(wb_stb_i && wb_cyc_i))
      else $error("ack without a preceding stb and cyc");

   set_stb_with_ack: assert property (@(posedge wb_clk) disable iff (por_rst)
      set_stb_i |-> wb_ack_o)
      else $error("settings strobe without ack");

   // Mask 0x1E with software bits 0 leaves only the run flags
   reset_values: assert property (@(posedge wb_clk)
      $fell(por_rst) |-> (lms_res_o == 2'b00 && phy_resetn_o
         && div_sw1_o == DIVSW_RESET && div_sw2_o == DIVSW_RESET
         && leds_o[4:1] == run_flags_i && leds_o[7:5] == 3'b000 && !leds_o[0]))
      else $error("outputs differ from reset values after power-on reset");

endmodule

bind umtrx_ctrl_top umtrx_ctrl_assert i_umtrx_ctrl_assert (
   .wb_clk       (wb_clk),
   .por_rst      (por_rst),
   .wb_stb_i     (wb_stb_i),
   .wb_cyc_i     (wb_cyc_i),
   .wb_ack_o     (wb_ack_o),
   .set_stb_i    (set_stb),
   .lms_res_o    (lms_res_o),
   .phy_resetn_o (phy_resetn_o),
   .div_sw1_o    (div_sw1_o),
   .div_sw2_o    (div_sw2_o),
   .leds_o       (leds_o),
   .run_flags_i  (run_flags_i)
);

// File: tests/umtrx_ctrl_tb.sv
// Control-plane testbench
// Replays bus operations and pin checks from the test data file,
// with a watchdog sized from the number of records

module umtrx_ctrl_tb;
   import umtrx_ctrl_pkg::*;

   localparam int REC_W   = 7;
   localparam int MAX_REC = 64;

   logic              wb_clk;
   logic              por_rst;
   logic [WB_AW-1:0]  wb_adr;
   logic [WB_DW-1:0]  wb_dat_w;
   logic [WB_DW-1:0]  wb_dat_r;
   logic              wb_we;
   logic              wb_stb;
   logic              wb_cyc;
   logic              wb_ack;
   logic              aux_ld1;
   logic              aux_ld2;
   logic              button;
   logic [RUN_W-1:0]  run_flags;
   logic [1:0]        lms_res;
   logic              phy_resetn;
   logic              div_sw1;
   logic              div_sw2;
   logic [LED_W-1:0]  leds;
   logic [31:0]       pins;
   logic              rd_chk;
   logic              pin_chk;
   logic              test_end;
   logic              done;
   logic [31:0]       exp_val;
   logic [7:0]        test_num;
   int                err_cnt;
   int                chk_cnt;
   logic [31:0]       tdata [0:REC_W*MAX_REC-1];
   int                n_rec;
   logic              loaded = 1'b0;

   assign pins = {19'b0, div_sw2, div_sw1, phy_resetn, lms_res, leds};

   umtrx_ctrl_top i_umtrx_ctrl_top (
      .wb_clk (wb_clk), .por_rst (por_rst),
      .wb_adr_i (wb_adr), .wb_dat_i (wb_dat_w), .wb_dat_o (wb_dat_r),
      .wb_we_i (wb_we), .wb_stb_i (wb_stb), .wb_cyc_i (wb_cyc), .wb_ack_o (wb_ack),
      .aux_ld1_i (aux_ld1), .aux_ld2_i (aux_ld2), .button_i (button),
      .run_flags_i (run_flags), .lms_res_o (lms_res), .phy_resetn_o (phy_resetn),
      .div_sw1_o (div_sw1), .div_sw2_o (div_sw2), .leds_o (leds)
   );

   umtrx_ctrl_checker i_checker (
      .wb_clk (wb_clk), .wb_ack_i (wb_ack), .wb_dat_i (wb_dat_r), .pins_i (pins),
      .rd_chk_i (rd_chk), .pin_chk_i (pin_chk), .exp_i (exp_val), .test_i (test_num),
      .test_end_i (test_end), .done_i (done), .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt)
   );

   initial begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Bus and check helpers, all drives land 1 unit after the edge

   task automatic next_cycle();
      @(posedge wb_clk);
      #1;
   endtask

   task automatic bus_access(input logic we, input logic [WB_AW-1:0] adr,
                             input logic [WB_DW-1:0] dat);
      wb_adr   = adr;
      wb_dat_w = dat;
      wb_we    = we;
      wb_stb   = 1'b1;
      wb_cyc   = 1'b1;
      rd_chk   = ~we;
      do
         next_cycle();
      while (!wb_ack);
      wb_stb = 1'b0;
      wb_cyc = 1'b0;
      wb_we  = 1'b0;
      // Checker samples the read data on the next edge
      next_cycle();
      rd_chk = 1'b0;
   endtask

   task automatic settle_and_check_pins();
      // Room for the bootloader reset pulse to land
      repeat (3) next_cycle();
      pin_chk = 1'b1;
      next_cycle();
      pin_chk = 1'b0;
   endtask

   task automatic finish_test(input int t);
      test_num = t[7:0];
      test_end = 1'b1;
      next_cycle();
      test_end = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      int   base;
      int   cur_test;
      logic bad_op;
      por_rst = 1'b1;
      wb_adr = '0;
      wb_dat_w = '0;
      wb_we = 1'b0;
      wb_stb = 1'b0;
      wb_cyc = 1'b0;
      aux_ld1 = 1'b0;
      aux_ld2 = 1'b0;
      button = 1'b0;
      run_flags = '0;
      rd_chk = 1'b0;
      pin_chk = 1'b0;
      test_end = 1'b0;
      done = 1'b0;
      exp_val = '0;
      test_num = '0;
      bad_op = 1'b0;
      cur_test = -1;
      $readmemh("tests/umtrx_ctrl_testdata.txt", tdata);
      n_rec = 0;
      while (n_rec < MAX_REC && tdata[n_rec*REC_W] !== 32'hF)
         n_rec++;
      loaded = 1'b1;
      repeat (2) @(posedge wb_clk);
      #1;
      por_rst = 1'b0;
      for (int idx = 0; idx < n_rec; idx++) begin
         base = idx * REC_W;
         if (cur_test >= 0 && tdata[base+6] != cur_test)
            finish_test(cur_test);
         cur_test = tdata[base+6];
         test_num = cur_test[7:0];
         exp_val = tdata[base+5];
         {aux_ld2, aux_ld1, button} = tdata[base+3][2:0];
         run_flags = tdata[base+4][RUN_W-1:0];
         case (tdata[base])
            32'h0: bus_access(1'b1, tdata[base+1][WB_AW-1:0], tdata[base+2]);
            32'h1: bus_access(1'b0, tdata[base+1][WB_AW-1:0], tdata[base+2]);
            32'h2: settle_and_check_pins();
            default: begin
               $display("Unknown operation in test data record %0d", idx);
               bad_op = 1'b1;
            end
         endcase
      end
      if (cur_test >= 0)
         finish_test(cur_test);
      done = 1'b1;
      next_cycle();
      done = 1'b0;
      if (err_cnt == 0 && chk_cnt > 0 && !bad_op)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // Watchdog, 20 cycles per record plus margin
   initial begin
      wait (loaded);
      #((n_rec * 20 + 100) * 10);
      $display("Timeout: the test sequence did not complete in time");
      $display("Regression failed");
      $finish;
   end

endmodule

// File: umtrx_ctrl_top.f
design/umtrx_ctrl_pkg.sv
design/settings_wb_slave.sv
design/misc_settings_regs.sv
design/boot_reset_ctrl.sv
design/umtrx_ctrl_top.sv
tests/umtrx_ctrl_checker.sv
tests/umtrx_ctrl_assert.sv
tests/umtrx_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the control-plane testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f umtrx_ctrl_top.f \
   --top-module umtrx_ctrl_tb -o umtrx_ctrl_sim > build.log 2>&1 \
   && ./obj_dir/umtrx_ctrl_sim > sim.log 2>&1 \
   || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "^Regression passed$" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }

// File: tests/umtrx_ctrl_testdata.txt
// Columns: op (0 write, 1 read, 2 check pins, F end) addr data status(ld2,ld1,btn) run expected test
// Pin word: bit 12 div_sw2, 11 div_sw1, 10 phy_resetn, 9:8 lms_res, 7:0 leds
2 0000 00000000 0 0 00001C00 01
2 0000 00000000 0 A 00001C14 01
0 7000 FFFFFFFF 0 0 00000000 02
2 0000 00000000 0 0 00001F00 02
0 7010 00000003 0 0 00000000 02
0 72D0 FFFFFFFE 0 0 00000000 02
0 72D4 00000002 0 0 00000000 02
2 0000 00000000 0 0 00000300 02
0 7004 FFFFFFFF 0 0 00000000 02
0 701C FFFFFFFF 0 0 00000000 02
0 1000 00000000 0 0 00000000 02
2 0000 00000000 0 0 00000300 02
0 700C 0001FFA5 0 0 00000000 03
2 0000 00000000 0 0 000003A1 03
2 0000 00000000 0 F 000003BF 03
0 7018 0000FF00 0 0 00000000 03
2 0000 00000000 0 F 000003A5 03
0 7018 000000FF 0 0 00000000 03
2 0000 00000000 0 5 0000030A 03
0 7018 0000003C 0 0 00000000 03
2 0000 00000000 0 9 00000391 03
1 5C30 00000000 0 0 00090000 04
1 5C34 00000000 7 0 0000E000 04
1 5C34 00000000 2 0 00004000 04
1 5C34 00000000 5 0 0000A000 04
1 5C00 00000000 7 0 00000000 04
1 1234 00000000 7 0 00000000 04
1 7030 00000000 7 0 00000000 04
0 7014 00000001 0 0 00000000 05
2 0000 00000000 0 0 00001C00 05
0 7000 00000002 0 0 00000000 05
0 700C 00000033 0 0 00000000 05
2 0000 00000000 0 0 00001E21 05
0 7014 00000001 0 0 00000000 05
2 0000 00000000 0 0 00001E21 05
0 7014 00000000 0 0 00000000 05
0 7014 00000001 0 0 00000000 05
2 0000 00000000 0 0 00001E21 05
F 0000 00000000 0 0 00000000 00
